// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    import uart_cfg_pkg::*;
    import uart_reg_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_CASES       = 6;
    localparam int LOOP_BYTES      = 4;
    localparam int STATUS_TX_BUSY  = 0;
    localparam int STATUS_RX_VALID = 2;
    localparam int FRAME_CLKS      = (DATA_BITS + 2) * CLKS_PER_BIT;
    // Forty bit times for each table entry plus a fixed margin.
    localparam int WATCHDOG_CLKS   = (NUM_CASES * 40 + 200) * CLKS_PER_BIT;

    typedef struct packed {
        logic [7:0]   data;
        logic         stop_good;
        uart_status_t status;
    } rx_case_t;

    logic        clk;
    logic        rst;
    logic        cs;
    logic        rw;
    logic [1:0]  addr;
    logic [7:0]  data_in;
    logic        drv_rxd;
    logic        loop_en;
    logic        rxd;
    logic [7:0]  data_out;
    logic        txd;
    logic        irq;
    logic [31:0] lfsr;
    int          cycle = 0;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    rx_case_t    rx_cases [NUM_CASES];

    assign rxd = loop_en ? txd : drv_rxd;

    uart_top u_uart_top (
        .clk      (clk),
        .rst      (rst),
        .cs       (cs),
        .rw       (rw),
        .addr     (addr),
        .data_in  (data_in),
        .rxd      (rxd),
        .data_out (data_out),
        .txd      (txd),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CLKS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            $display("mismatch %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input uart_status_t exp,
                                input uart_status_t got);
        if (got !== exp) begin
            $display("mismatch %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("mismatch %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        if (errors == errors_at_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    // Bus tasks start and end on a falling edge.
    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        cs      = 1'b1;
        rw      = 1'b0;
        addr    = a;
        data_in = d;
        @(negedge clk);
        cs = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
        cs   = 1'b1;
        rw   = 1'b1;
        addr = a;
        @(negedge clk);
        cs = 1'b0;
        d  = data_out;
    endtask

    task automatic wait_status(input int pos, input logic level, output uart_status_t st);
        int         polls;
        logic [7:0] rd;
        polls = 0;
        bus_read(ADDR_STATUS, rd);
        while (rd[pos] !== level && polls < 4 * FRAME_CLKS) begin
            bus_read(ADDR_STATUS, rd);
            polls++;
        end
        if (rd[pos] !== level) begin
            $display("status bit %0d never reached %0b while polling", pos, level);
            errors++;
        end
        st = rd;
    endtask

    // Sends one frame on rxd and leaves one idle bit after it.
    task automatic send_frame(input logic [7:0] b, input logic stop_good);
        drv_rxd = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < DATA_BITS; i++) begin
            drv_rxd = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        drv_rxd = stop_good;
        repeat (CLKS_PER_BIT) @(negedge clk);
        drv_rxd = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // Samples txd at the bit centres, counted from the start bit.
    task automatic receive_frame(output logic [7:0] b, output logic stop, output int start_at);
        int polls;
        polls = 0;
        b     = '0;
        stop  = 1'b0;
        while (txd !== 1'b0 && polls < 2 * FRAME_CLKS) begin
            @(negedge clk);
            polls++;
        end
        start_at = cycle;
        if (txd !== 1'b0) begin
            $display("no start bit appeared on txd");
            errors++;
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_level("txd start bit", 1'b0, txd);
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            stop = txd;
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        logic [7:0]   rd;
        logic [7:0]   b0;
        logic [7:0]   b1;
        logic [7:0]   got0;
        logic [7:0]   got1;
        logic         stop0;
        logic         stop1;
        int           t0;
        int           t1;
        int           start;
        uart_status_t st;

        rst     = 1'b1;
        cs      = 1'b0;
        rw      = 1'b0;
        addr    = 2'd0;
        data_in = 8'h00;
        drv_rxd = 1'b1;
        loop_en = 1'b0;
        lfsr    = 32'hac99;

        // Status 04 is rx_valid alone, 0c adds rx_frame_err.
        rx_cases[0] = '{data: 8'h55, stop_good: 1'b1, status: 8'h04};
        rx_cases[1] = '{data: 8'ha3, stop_good: 1'b0, status: 8'h0c};
        rx_cases[2] = '{data: 8'h00, stop_good: 1'b1, status: 8'h04};
        rx_cases[3] = '{data: 8'hff, stop_good: 1'b0, status: 8'h0c};
        rx_cases[4] = '{data: 8'h81, stop_good: 1'b1, status: 8'h04};
        rx_cases[5] = '{data: 8'h7e, stop_good: 1'b1, status: 8'h04};

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        start = errors;
        check_level("txd", 1'b1, txd);
        check_level("irq", 1'b0, irq);
        check_byte("data_out", 8'h00, data_out);
        bus_read(ADDR_STATUS, rd);
        check_status("status", '0, rd);
        bus_read(ADDR_CTRL, rd);
        check_byte("ctrl", 8'h00, rd);
        end_test("reset values", start);

        start = errors;
        random_byte(b0);
        random_byte(b1);
        bus_write(ADDR_DATA, b0);
        fork
            begin
                receive_frame(got0, stop0, t0);
                receive_frame(got1, stop1, t1);
            end
            begin
                wait (txd === 1'b0);
                @(negedge clk);
                bus_read(ADDR_STATUS, rd);
                check_status("status during frame", 8'h01, rd);
                bus_write(ADDR_DATA, b1);
            end
        join
        check_byte("txd first byte", b0, got0);
        check_level("txd first stop bit", 1'b1, stop0);
        check_byte("txd second byte", b1, got1);
        check_level("txd second stop bit", 1'b1, stop1);
        if (t1 - t0 != FRAME_CLKS) begin
            $display("second frame started %0d cycles after the first, not %0d",
                     t1 - t0, FRAME_CLKS);
            errors++;
        end
        wait_status(STATUS_TX_BUSY, 1'b0, st);
        check_status("status after frames", '0, st);
        end_test("tx two frames", start);

        bus_write(ADDR_CTRL, 8'(1 << CTRL_IRQ_EN));
        for (int n = 0; n < NUM_CASES; n++) begin
            start = errors;
            send_frame(rx_cases[n].data, rx_cases[n].stop_good);
            wait_status(STATUS_RX_VALID, 1'b1, st);
            check_status("status", rx_cases[n].status, st);
            check_level("irq", 1'b1, irq);
            bus_read(ADDR_DATA, rd);
            check_byte("rx data", rx_cases[n].data, rd);
            bus_read(ADDR_STATUS, rd);
            check_status("status after read", '0, rd);
            check_level("irq", 1'b0, irq);
            end_test($sformatf("rx frame %0d", n), start);
        end

        start = errors;
        random_byte(b0);
        random_byte(b1);
        send_frame(b0, 1'b1);
        send_frame(b1, 1'b1);
        bus_read(ADDR_STATUS, rd);
        check_status("status with overrun", 8'h14, rd);
        bus_read(ADDR_STATUS, rd);
        check_status("status after clear", 8'h04, rd);
        bus_read(ADDR_DATA, rd);
        check_byte("rx data kept", b0, rd);
        end_test("rx overrun", start);

        loop_en = 1'b1;
        for (int k = 0; k < LOOP_BYTES; k++) begin
            start = errors;
            random_byte(b0);
            bus_write(ADDR_DATA, b0);
            wait_status(STATUS_RX_VALID, 1'b1, st);
            check_level("rx_frame_err", 1'b0, st.rx_frame_err);
            bus_read(ADDR_DATA, rd);
            check_byte("loopback data", b0, rd);
            end_test($sformatf("loopback byte %0d", k), start);
        end

        $display("tests ok: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/uart_cfg_pkg.sv ====
`default_nettype none

package uart_cfg_pkg;

    // ==============================
    // Serial timing
    // ==============================

    // System clock rate in Hz.
    localparam int CLK_HZ = 1_843_200;

    // Line rate in bits per second.
    localparam int BAUD = 115_200;

    localparam int CLKS_PER_BIT = CLK_HZ / BAUD;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;

    // ==============================
    // Frame shape
    // ==============================

    localparam int DATA_BITS = 8;

    localparam int DIV_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(DATA_BITS);

    // Bit-time divider and data-bit index.
    typedef logic [DIV_W-1:0] div_cnt_t;
    typedef logic [IDX_W-1:0] bit_cnt_t;

endpackage

`default_nettype wire

// ==== logic/uart_hold_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_hold_buf #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     put,
    input  payload_t put_data,
    input  logic     take,
    output logic     full,
    output payload_t data
);

    logic load;

    // A put into a full buffer is dropped unless the word leaves on the same cycle.
    assign load = put && (!full || take);

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data <= put_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_reg_pkg.sv ====
`default_nettype none

package uart_reg_pkg;

    // ==============================
    // Register map
    // ==============================

    localparam logic [1:0] ADDR_DATA   = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;
    localparam logic [1:0] ADDR_CTRL   = 2'd2;

    // Control register bit positions.
    localparam int CTRL_IRQ_EN = 0;

    // Status byte, bit 0 at the bottom.
    typedef struct packed {
        logic [2:0] reserved;
        logic       rx_overrun;
        logic       rx_frame_err;
        logic       rx_valid;
        logic       tx_full;
        logic       tx_busy;
    } uart_status_t;

    // Received byte with its stop-bit check.
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_word_t;

endpackage

`default_nettype wire

// ==== logic/uart_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cs,
    input  logic                   rw,
    input  logic [1:0]             addr,
    input  logic [7:0]             data_in,
    output logic [7:0]             data_out,
    output logic                   tx_put,
    output logic [7:0]             tx_put_data,
    input  logic                   tx_full,
    input  logic                   tx_busy,
    input  logic                   rx_full,
    input  uart_reg_pkg::rx_word_t rx_word,
    input  logic                   rx_put,
    output logic                   rx_take,
    output logic                   irq
);

    import uart_reg_pkg::*;

    logic         wr_acc;
    logic         rd_acc;
    logic         status_rd;
    logic         overrun_set;
    logic         rx_overrun;
    logic [7:0]   ctrl;
    logic [7:0]   rd_data;
    uart_status_t status;

    assign wr_acc    = cs && !rw;
    assign rd_acc    = cs && rw;
    assign status_rd = rd_acc && (addr == ADDR_STATUS);
    assign rx_take   = rd_acc && (addr == ADDR_DATA);

    // New word arrives while the old one is still waiting.
    assign overrun_set = rx_put && rx_full && !rx_take;

    always_comb begin
        status              = '0;
        status.tx_busy      = tx_busy;
        status.tx_full      = tx_full;
        status.rx_valid     = rx_full;
        status.rx_frame_err = rx_full && rx_word.frame_err;
        status.rx_overrun   = rx_overrun;
    end

    always_comb begin
        case (addr)
            ADDR_DATA:   rd_data = rx_word.data;
            ADDR_STATUS: rd_data = status;
            ADDR_CTRL:   rd_data = ctrl;
            default:     rd_data = 8'h00;
        endcase
    end

    // ==============================
    // Registers
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl       <= '0;
            rx_overrun <= 1'b0;
            data_out   <= '0;
            tx_put     <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (wr_acc && addr == ADDR_CTRL) begin
                ctrl <= data_in;
            end
            if (overrun_set) begin
                rx_overrun <= 1'b1;
            end else if (status_rd) begin
                rx_overrun <= 1'b0;
            end
            if (rd_acc) begin
                data_out <= rd_data;
            end
            tx_put <= wr_acc && (addr == ADDR_DATA);
            irq    <= rx_full && ctrl[CTRL_IRQ_EN];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && addr == ADDR_DATA) begin
            tx_put_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rxd,
    output logic                  put,
    output uart_reg_pkg::rx_word_t word
);

    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    div_cnt_t             div_cnt;
    bit_cnt_t             bit_idx;
    logic [DATA_BITS-1:0] shift;
    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 rxd_prev;
    logic                 fall;
    logic                 half_done;
    logic                 bit_done;
    logic                 sample_data;
    logic                 sample_stop;

    // ==============================
    // Input synchroniser
    // ==============================

    // Idle line is high, so the flops come out of reset at 1.
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall        = rxd_prev && !rxd_sync;
    assign half_done   = (div_cnt == div_cnt_t'(HALF_BIT - 1));
    assign bit_done    = (div_cnt == div_cnt_t'(CLKS_PER_BIT - 1));
    assign sample_data = (state == RX_DATA) && bit_done;
    assign sample_stop = (state == RX_STOP) && bit_done;

    // ==============================
    // Frame sequencing
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            div_cnt <= '0;
            bit_idx <= '0;
            put     <= 1'b0;
        end else begin
            put <= sample_stop;
            case (state)
                RX_IDLE: begin
                    div_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_done) begin
                        // A glitch shorter than half a bit is ignored.
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                        div_cnt <= '0;
                        bit_idx <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    div_cnt <= bit_done ? '0 : div_cnt + 1'b1;
                    if (bit_done) begin
                        if (bit_idx == bit_cnt_t'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    div_cnt <= bit_done ? '0 : div_cnt + 1'b1;
                    if (bit_done) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample_data) begin
            shift <= {rxd_sync, shift[DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (sample_stop) begin
            word.data      <= shift;
            word.frame_err <= !rxd_sync;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs,
    input  logic       rw,
    input  logic [1:0] addr,
    input  logic [7:0] data_in,
    input  logic       rxd,
    output logic [7:0] data_out,
    output logic       txd,
    output logic       irq
);

    import uart_reg_pkg::*;

    logic       tx_put;
    logic [7:0] tx_put_data;
    logic       tx_full;
    logic [7:0] tx_byte;
    logic       tx_take;
    logic       tx_busy;
    logic       rx_put;
    rx_word_t   rx_put_word;
    logic       rx_take;
    logic       rx_full;
    rx_word_t   rx_word;

    uart_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cs          (cs),
        .rw          (rw),
        .addr        (addr),
        .data_in     (data_in),
        .data_out    (data_out),
        .tx_put      (tx_put),
        .tx_put_data (tx_put_data),
        .tx_full     (tx_full),
        .tx_busy     (tx_busy),
        .rx_full     (rx_full),
        .rx_word     (rx_word),
        .rx_put      (rx_put),
        .rx_take     (rx_take),
        .irq         (irq)
    );

    // ==============================
    // Transmit side
    // ==============================

    uart_hold_buf #(
        .payload_t (logic [7:0])
    ) u_tx_buf (
        .clk      (clk),
        .rst      (rst),
        .put      (tx_put),
        .put_data (tx_put_data),
        .take     (tx_take),
        .full     (tx_full),
        .data     (tx_byte)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .tx_full (tx_full),
        .tx_byte (tx_byte),
        .take    (tx_take),
        .busy    (tx_busy),
        .txd     (txd)
    );

    // ==============================
    // Receive side
    // ==============================

    uart_rx u_rx (
        .clk  (clk),
        .rst  (rst),
        .rxd  (rxd),
        .put  (rx_put),
        .word (rx_put_word)
    );

    uart_hold_buf #(
        .payload_t (rx_word_t)
    ) u_rx_buf (
        .clk      (clk),
        .rst      (rst),
        .put      (rx_put),
        .put_data (rx_put_word),
        .take     (rx_take),
        .full     (rx_full),
        .data     (rx_word)
    );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_full,
    input  logic [7:0] tx_byte,
    output logic       take,
    output logic       busy,
    output logic       txd
);

    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t            state;
    div_cnt_t             div_cnt;
    bit_cnt_t             bit_idx;
    logic [DATA_BITS-1:0] shift;
    logic                 bit_done;
    logic                 start_frame;
    logic                 shift_en;
    logic                 last_bit;

    assign bit_done = (div_cnt == div_cnt_t'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_idx == bit_cnt_t'(DATA_BITS - 1));

    // Back-to-back frames start straight out of the stop bit.
    assign start_frame = tx_full && ((state == TX_IDLE) || (state == TX_STOP && bit_done));
    assign shift_en    = bit_done && ((state == TX_START) || (state == TX_DATA));

    assign take = start_frame;
    assign busy = (state != TX_IDLE) || tx_full;

    // ==============================
    // Frame sequencing
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            div_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else if (start_frame) begin
            state   <= TX_START;
            div_cnt <= '0;
            txd     <= 1'b0;
        end else begin
            div_cnt <= (state == TX_IDLE || bit_done) ? '0 : div_cnt + 1'b1;
            case (state)
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        txd     <= shift[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (last_bit) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shift[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    txd <= 1'b1;
                end
            endcase
        end
    end

    // LSB first, so the next bit is always at the bottom.
    always_ff @(posedge clk) begin
        if (start_frame) begin
            shift <= tx_byte;
        end else if (shift_en) begin
            shift <= {1'b0, shift[DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module uart_tb -f tb.f -o uart_sim

./obj_dir/uart_sim > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb.f ====
logic/uart_cfg_pkg.sv
logic/uart_reg_pkg.sv
logic/uart_hold_buf.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
dv/uart_tb.sv
